// ==== design/core_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_sequencer import rv32i_types::*; (
	input  wire  clk,
	input  wire  rst,
	input  wire  start,
	input  wire  halt_req,
	output logic run,
	output logic flush,
	output logic halted
);

	seq_state_t state;
	seq_state_t state_nxt;

	assign run = (state == RUN);
	assign halted = (state == HALTED);
	assign flush = start && (state == IDLE || state == HALTED); // same cycle as start

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (start) state_nxt = RUN;
			RUN:     if (halt_req) state_nxt = DRAIN;
			DRAIN:   state_nxt = HALTED; // ecall writeback lands here
			HALTED:  if (start) state_nxt = RUN;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// ecall only executes while fetch and execute are live
	a_halt_in_run: assert property (@(posedge clk) disable iff (rst)
		halt_req |-> state == RUN)
		else $error("halt_req outside RUN");

	// start strobe is gone by the first run cycle
	a_flush_pulse: assert property (@(posedge clk) disable iff (rst)
		flush |=> !start)
		else $error("start held past the flush cycle");

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_defs.svh"

module execute_stage import rv32i_types::*; (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          run,
	input  wire [$clog2(`REG_COUNT)-1:0] dbg_addr,
	fetch_bus.dst                        fb,
	wb_bus.src                           wb,
	output logic                         halt_req,
	output logic [`XLEN-1:0]             dbg_data
);

	localparam int RW = $clog2(`REG_COUNT);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	rv32_opcode_t     opcode;
	logic [2:0]       funct3;
	logic [RW-1:0]    rs1, rs2, rd;
	ctrl_word_t       ctrl;
	logic [`XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
	logic [`XLEN-1:0] rs1_val, rs2_val, op_b, alu_out, result;
	logic             br_taken;
	logic             exec_ok;

	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b100:  return ALU_XOR;
			3'b101:  return ALU_SRL;
			3'b110:  return ALU_OR;
			3'b111:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	assign opcode = rv32_opcode_t'(fb.instr[6:0]);
	assign funct3 = fb.instr[14:12];
	assign rd  = fb.instr[11:7];
	assign rs1 = fb.instr[19:15];
	assign rs2 = fb.instr[24:20];

	assign imm_i = {{20{fb.instr[31]}}, fb.instr[31:20]};
	assign imm_u = {fb.instr[31:12], 12'b0};
	assign imm_b = {{19{fb.instr[31]}}, fb.instr[31], fb.instr[7], fb.instr[30:25],
		fb.instr[11:8], 1'b0};
	assign imm_j = {{11{fb.instr[31]}}, fb.instr[31], fb.instr[19:12], fb.instr[20],
		fb.instr[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		case (opcode)
			OPC_OP: begin
				ctrl.reg_we = 1'b1;
				ctrl.alu_op = alu_sel(funct3, fb.instr[30]);
			end
			OPC_OP_IMM: begin
				ctrl.reg_we = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = alu_sel(funct3, 1'b0); // no subi
			end
			OPC_LUI: begin
				ctrl.reg_we = 1'b1;
				ctrl.is_lui = 1'b1;
			end
			OPC_BRANCH: begin
				ctrl.is_branch = 1'b1;
				ctrl.branch_op = branch_op_t'(funct3);
			end
			OPC_JAL: begin
				ctrl.reg_we = 1'b1;
				ctrl.is_jal = 1'b1;
			end
			OPC_SYSTEM: ctrl.is_halt = 1'b1;
			default: ctrl = '0; // unsupported, retires as a nop
		endcase
	end

	// wb register holds the value written at the end of this cycle
	assign rs1_val = (rs1 == '0) ? '0 :
		(wb.valid && wb.we && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 :
		(wb.valid && wb.we && wb.rd == rs2) ? wb.data : regs[rs2];
	assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

	assign op_b = ctrl.use_imm ? imm_i : rs2_val;

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD: alu_out = rs1_val + op_b;
			ALU_SUB: alu_out = rs1_val - op_b;
			ALU_AND: alu_out = rs1_val & op_b;
			ALU_OR:  alu_out = rs1_val | op_b;
			ALU_XOR: alu_out = rs1_val ^ op_b;
			ALU_SLT: alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
			ALU_SLL: alu_out = rs1_val << op_b[4:0];
			ALU_SRL: alu_out = rs1_val >> op_b[4:0];
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		case (ctrl.branch_op)
			BR_EQ:   br_taken = (rs1_val == rs2_val);
			BR_NE:   br_taken = (rs1_val != rs2_val);
			BR_LT:   br_taken = ($signed(rs1_val) < $signed(rs2_val));
			BR_GE:   br_taken = ($signed(rs1_val) >= $signed(rs2_val));
			default: br_taken = 1'b0;
		endcase
	end

	assign result = ctrl.is_jal ? fb.pc + `XLEN'd4 : ctrl.is_lui ? imm_u : alu_out;

	// run drops the cycle after ecall, which kills the younger slot
	assign exec_ok = fb.valid && run;
	assign halt_req = exec_ok && ctrl.is_halt;
	assign fb.redirect = exec_ok && (ctrl.is_jal || (ctrl.is_branch && br_taken));
	assign fb.target = fb.pc + (ctrl.is_jal ? imm_j : imm_b);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb.valid <= 1'b0;
			wb.we <= 1'b0;
		end else begin
			wb.valid <= exec_ok;
			wb.we <= exec_ok && ctrl.reg_we && rd != '0; // x0 stays zero
		end
	end

	always_ff @(posedge clk) begin
		wb.rd <= rd;
		wb.data <= result;
	end

	always_ff @(posedge clk) begin
		if (wb.valid && wb.we)
			regs[wb.rd] <= wb.data;
	end

	// slot behind a redirect arrives as a bubble
	a_redirect_halt: assert property (@(posedge clk) disable iff (rst)
		fb.redirect |=> !fb.valid)
		else $error("valid slot right after a redirect");

	// ecall retires one cycle later, nothing behind it does
	a_halt_drain: assert property (@(posedge clk) disable iff (rst)
		halt_req |=> wb.valid ##1 !wb.valid)
		else $error("writeback after ecall");

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_defs.svh"

module fetch_stage (
	input wire                            clk,
	input wire                            rst,
	input wire                            run,
	input wire                            flush,
	input wire                            prog_we,
	input wire [$clog2(`IMEM_WORDS)-1:0]  prog_addr,
	input wire [`XLEN-1:0]                prog_data,
	fetch_bus.src                         fb
);

	localparam int AW = $clog2(`IMEM_WORDS);

	logic [`XLEN-1:0] imem [`IMEM_WORDS];
	logic [`XLEN-1:0] pc;
	logic [AW-1:0]    pc_idx;

	assign pc_idx = pc[AW+1:2]; // word address

	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	always_ff @(posedge clk) begin
		if (rst || flush)
			pc <= '0;
		else if (run) begin
			if (fb.redirect)
				pc <= fb.target;
			else
				pc <= pc + `XLEN'd4;
		end
	end

	// the slot fetched alongside a redirect is dropped
	always_ff @(posedge clk) begin
		if (rst)
			fb.valid <= 1'b0;
		else
			fb.valid <= run && !flush && !fb.redirect;
	end

	always_ff @(posedge clk) begin
		fb.pc <= pc;
		fb.instr <= imem[pc_idx];
	end

endmodule

`default_nettype wire

// ==== design/pipe_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_defs.svh"

// fetch to execute, with the redirect path going back
interface fetch_bus;
	logic             valid;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] instr;
	logic             redirect;
	logic [`XLEN-1:0] target;

	modport src (output valid, pc, instr, input redirect, target);
	modport dst (input valid, pc, instr, output redirect, target);
endinterface

// execute-to-writeback register contents
interface wb_bus;
	logic                          valid;
	logic                          we;
	logic [$clog2(`REG_COUNT)-1:0] rd;
	logic [`XLEN-1:0]              data;

	modport src (output valid, we, rd, data);
	modport mon (input valid);
endinterface

`default_nettype wire

// ==== design/run_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module run_counter (
	input  wire         clk,
	input  wire         rst,
	input  wire         flush,
	input  wire         run,
	wb_bus.mon          wb,
	output logic [31:0] cycle_count,
	output logic [31:0] retire_count
);

	// squashed slots never reach wb with valid set
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			cycle_count <= '0;
			retire_count <= '0;
		end else begin
			if (run)
				cycle_count <= cycle_count + 32'd1;
			if (wb.valid)
				retire_count <= retire_count + 32'd1; // also counts in DRAIN
		end
	end

endmodule

`default_nettype wire

// ==== design/rv32i_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_defs.svh"

module rv32i_core (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           start,
	input  wire                           prog_we,
	input  wire [$clog2(`IMEM_WORDS)-1:0] prog_addr,
	input  wire [`XLEN-1:0]               prog_data,
	input  wire [$clog2(`REG_COUNT)-1:0]  dbg_addr,
	output logic                          halted,
	output logic [`XLEN-1:0]              dbg_data,
	output logic [31:0]                   cycle_count,
	output logic [31:0]                   retire_count
);

	logic run;
	logic flush;
	logic halt_req;

	fetch_bus fb ();
	wb_bus    wb ();

	core_sequencer u_seq (
		.clk,
		.rst,
		.start,
		.halt_req,
		.run,
		.flush,
		.halted
	);

	run_counter u_cnt (
		.clk,
		.rst,
		.flush,
		.run,
		.wb(wb.mon), // retire tap
		.cycle_count,
		.retire_count
	);

	fetch_stage u_fetch (
		.clk,
		.rst,
		.run,
		.flush,
		.prog_we,
		.prog_addr,
		.prog_data,
		.fb(fb.src)
	);

	execute_stage u_exec (
		.clk,
		.rst,
		.run,
		.dbg_addr,
		.fb(fb.dst),
		.wb(wb.src),
		.halt_req,
		.dbg_data
	);

endmodule

`default_nettype wire

// ==== design/rv32i_defs.svh ====
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 hardwired to zero
`define REG_COUNT 32

// program memory depth in 32-bit words
`define IMEM_WORDS 256

`endif

// ==== design/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} rv32_opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_EQ = 3'b000,
		BR_NE = 3'b001,
		BR_LT = 3'b100, // signed
		BR_GE = 3'b101
	} branch_op_t;

	typedef enum logic [1:0] {IDLE, RUN, DRAIN, HALTED} seq_state_t;

	typedef struct packed {
		logic       reg_we;
		alu_op_t    alu_op;
		logic       use_imm;   // operand b from the I immediate
		logic       is_lui;
		logic       is_branch;
		branch_op_t branch_op;
		logic       is_jal;
		logic       is_halt;   // ecall
	} ctrl_word_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module rv32i_core_tb -Mdir obj_dir

./obj_dir/Vrv32i_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi

// ==== src.f ====
+incdir+design
design/rv32i_types.sv
design/pipe_bus.sv
design/core_sequencer.sv
design/run_counter.sv
design/fetch_stage.sv
design/execute_stage.sv
design/rv32i_core.sv
tests/rv32i_core_tb.sv

// ==== tests/program_input.txt ====
# P word_addr(hex) instr(hex) | R reg(dec) expected(hex) | C retire_count(dec) | E end
# program 1: ALU ops, lui, bypass chain, write to x0
P 00 00500093 # addi x1, x0, 5
P 01 ffd00113 # addi x2, x0, -3
P 02 002081b3 # add  x3, x1, x2
P 03 40208233 # sub  x4, x1, x2
P 04 0020f2b3 # and  x5, x1, x2
P 05 0020e333 # or   x6, x1, x2
P 06 0020c3b3 # xor  x7, x1, x2
P 07 00112433 # slt  x8, x2, x1
P 08 001094b3 # sll  x9, x1, x1
P 09 00115533 # srl  x10, x2, x1
P 0a 123455b7 # lui  x11, 0x12345
P 0b 6785e613 # ori  x12, x11, 0x678
P 0c 0ff67693 # andi x13, x12, 0xff
P 0d fff0c713 # xori x14, x1, -1
P 0e ffe12793 # slti x15, x2, -2
P 0f 00100813 # addi x16, x0, 1
P 10 00280813 # addi x16, x16, 2
P 11 00380813 # addi x16, x16, 3
P 12 00480813 # addi x16, x16, 4
P 13 00708013 # addi x0, x1, 7
P 14 00000073 # ecall
R 1 00000005
R 2 fffffffd
R 3 00000002
R 4 00000008
R 5 00000005
R 6 fffffffd
R 7 fffffff8
R 8 00000001
R 9 000000a0
R 10 07ffffff
R 11 12345000
R 12 12345678
R 13 00000078
R 14 fffffffa
R 15 00000001
R 16 0000000a
C 21
E
# program 2: taken and fall-through branches, jal, squash after ecall
P 00 00700093 # addi x1, x0, 7
P 01 ffc00113 # addi x2, x0, -4
P 02 00100a13 # addi x20, x0, 1
P 03 00108463 # beq  x1, x1, +8
P 04 06300a13 # addi x20, x0, 99 skipped
P 05 00209463 # bne  x1, x2, +8
P 06 05c00a13 # addi x20, x0, 92 skipped
P 07 00114463 # blt  x2, x1, +8
P 08 05d00a13 # addi x20, x0, 93 skipped
P 09 0020d463 # bge  x1, x2, +8
P 0a 05e00a13 # addi x20, x0, 94 skipped
P 0b 00208463 # beq  x1, x2, +8 not taken
P 0c 00100a93 # addi x21, x0, 1
P 0d 0020c463 # blt  x1, x2, +8 not taken
P 0e 002a8a93 # addi x21, x21, 2
P 0f 00115463 # bge  x2, x1, +8 not taken
P 10 004a8a93 # addi x21, x21, 4
P 11 00109463 # bne  x1, x1, +8 not taken
P 12 008a8a93 # addi x21, x21, 8
P 13 00c00b6f # jal  x22, +12
P 14 05f00a13 # addi x20, x0, 95 skipped
P 15 06000a13 # addi x20, x0, 96 skipped
P 16 015b0bb3 # add  x23, x22, x21
P 17 00000073 # ecall
P 18 06100a13 # addi x20, x0, 97 squashed by halt
R 1 00000007
R 2 fffffffc
R 20 00000001
R 21 0000000f
R 22 00000050
R 23 0000005f
C 18
E

// ==== tests/rv32i_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_defs.svh"

module rv32i_core_tb;

	logic             clk;
	logic             rst;
	logic             start;
	logic             prog_we;
	logic [7:0]       prog_addr;
	logic [`XLEN-1:0] prog_data;
	logic [4:0]       dbg_addr;
	wire              halted;
	wire  [`XLEN-1:0] dbg_data;
	wire  [31:0]      cycle_count;
	wire  [31:0]      retire_count;

	// one entry per data line, kind is P, R, C or E
	byte         rec_kind[$];
	logic [31:0] rec_a[$];
	logic [31:0] rec_b[$];
	int          p_total;
	int          limit;

	rv32i_core DUT (
		.clk,
		.rst,
		.start,
		.prog_we,
		.prog_addr,
		.prog_data,
		.dbg_addr,
		.halted,
		.dbg_data,
		.cycle_count,
		.retire_count
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
		else fail_now($sformatf("CHECK FAILED: %s expected %h got %h", name, exp, got));
	endtask

	task automatic read_records();
		int          fd;
		int          n;
		string       line;
		string       rest;
		byte         kind;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("tests/program_input.txt", "r");
		if (fd == 0)
			fail_now("could not open tests/program_input.txt");
		p_total = 0;
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 1)
				continue;
			kind = line.getc(0);
			if (kind != "P" && kind != "R" && kind != "C" && kind != "E")
				continue; // comments and blank lines
			rest = line.substr(1, line.len() - 1);
			a = '0;
			b = '0;
			case (kind)
				"P": n = $sscanf(rest, "%h %h", a, b);
				"R": n = $sscanf(rest, "%d %h", a, b);
				"C": n = $sscanf(rest, "%d", a);
				default: n = 0;
			endcase
			if (((kind == "P" || kind == "R") && n != 2) || (kind == "C" && n != 1))
				fail_now({"malformed line in program file: ", line});
			if (kind == "P")
				p_total++;
			rec_kind.push_back(kind);
			rec_a.push_back(a);
			rec_b.push_back(b);
		end
		$fclose(fd);
	endtask

	// dbg path is combinational, sample away from the edge
	task automatic read_reg(input logic [4:0] r, output logic [31:0] val);
		@(posedge clk);
		dbg_addr <= r;
		@(negedge clk);
		val = dbg_data;
	endtask

	task automatic run_program(input int prog_no, input int first, input int last);
		int          i;
		int          waited;
		logic [31:0] val;
		logic [31:0] cyc_at_halt;
		logic [31:0] ret_at_halt;
		for (i = first; i < last; i++) begin
			if (rec_kind[i] == "P") begin
				@(posedge clk);
				prog_we <= 1'b1;
				prog_addr <= rec_a[i][7:0];
				prog_data <= rec_b[i];
			end
		end
		@(posedge clk);
		prog_we <= 1'b0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_value("cycle_count", 32'd0, cycle_count); // flush cleared, nothing counted yet
		check_value("retire_count", 32'd0, retire_count);

		waited = 0;
		while (!halted) begin
			if (waited >= limit)
				fail_now($sformatf("timeout: program %0d did not halt within %0d cycles",
					prog_no, limit));
			@(negedge clk);
			waited++;
		end
		cyc_at_halt = cycle_count;
		ret_at_halt = retire_count;

		for (i = first; i < last; i++) begin
			if (rec_kind[i] == "C")
				check_value("retire_count", rec_a[i], retire_count);
		end
		assert (cycle_count >= retire_count)
		else fail_now($sformatf("CHECK FAILED: cycle_count %h below retire_count %h",
			cycle_count, retire_count));

		for (i = first; i < last; i++) begin
			if (rec_kind[i] == "R") begin
				read_reg(rec_a[i][4:0], val);
				check_value($sformatf("dbg_data x%0d", rec_a[i]), rec_b[i], val);
			end
		end
		read_reg(5'd0, val);
		check_value("dbg_data x0", 32'd0, val);

		// still halted, counters frozen
		check_value("halted", 32'd1, {31'b0, halted});
		check_value("cycle_count", cyc_at_halt, cycle_count);
		check_value("retire_count", ret_at_halt, retire_count);
		$display("program %0d halted: %0d cycles, %0d retired", prog_no, cycle_count,
			retire_count);
	endtask

	initial begin
		int idx;
		int first;
		int prog_no;
		rst = 1'b1;
		start = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_addr = '0;

		read_records();
		limit = 3 * p_total + 50;

		repeat (5) @(posedge clk);
		rst <= 1'b0;

		idx = 0;
		prog_no = 0;
		while (idx < rec_kind.size()) begin
			first = idx;
			while (idx < rec_kind.size() && rec_kind[idx] != "E")
				idx++;
			prog_no++;
			run_program(prog_no, first, idx);
			idx++; // past the E line
		end

		if (prog_no == 0)
			fail_now("no program found in tests/program_input.txt");
		else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
